/* compile.f */
src/isaPkg.sv
src/pipePkg.sv
src/apbControl.sv
src/fetchStage.sv
src/decodeStage.sv
src/registerDE.sv
src/executeStage.sv
src/cpuTop.sv
sim/cpuTb_assert.sv
sim/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build the core and its testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module cpuTb -f compile.f -o cpuSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sim/cpuTb.sv */
// **********************************************************
// Testbench for cpuTop. Each table row loads two operands,
// runs a short program over APB and checks the ALU result,
// the branch outcome and the halt status
// Dmem is expected to power up as zero
// **********************************************************
`timescale 1ns/1ps

module cpuTb;
	import isaPkg::*;
	import pipePkg::*;

	typedef struct packed {
		aluFn_e            fn;
		logic              setFlags;
		cond_e             cond;
		logic              sameOps; // B copies A
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] expResult;
		logic              expTaken;
	} testRow_t;

	localparam int ROWS           = 11;
	localparam int TIMEOUT_CYCLES = ROWS * 200;
	localparam logic [APB_AW-1:0] CTRL_ADDR = '0;

	logic     clk;
	logic     reset;
	apbReq_t  apbIn;
	apbResp_t apbOut;
	int       errors;
	int       checks;
	int       cycles;
	integer   seed;

	// Operands and expected values are filled in by prepareRows
	testRow_t rows [ROWS] = '{
		'{ALU_ADD,  1'b1, COND_EQ, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_SUB,  1'b1, COND_EQ, 1'b1, '0, '0, '0, 1'b0}, // Zero result
		'{ALU_SUB,  1'b1, COND_LT, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_SUB,  1'b1, COND_GE, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_AND,  1'b0, COND_NE, 1'b0, '0, '0, '0, 1'b0}, // Keeps older flags
		'{ALU_OR,   1'b1, COND_NE, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_XOR,  1'b1, COND_EQ, 1'b1, '0, '0, '0, 1'b0},
		'{ALU_SHL,  1'b1, COND_NE, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_SHR,  1'b0, COND_AL, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_MOVB, 1'b1, COND_GE, 1'b0, '0, '0, '0, 1'b0},
		'{ALU_ADD,  1'b1, COND_LT, 1'b0, '0, '0, '0, 1'b0}
	};

	cpuTop i_cpuTop (
		.clk    (clk),
		.reset  (reset),
		.apbIn  (apbIn),
		.apbOut (apbOut)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [APB_AW-1:0] dmemAddr(input int word);
		return APB_AW'(32'h200 + word * 4);
	endfunction

	function automatic logic [APB_AW-1:0] imemAddr(input int word);
		return APB_AW'(32'h100 + word * 4);
	endfunction

	function automatic logic [DATA_W-1:0] encodeInstr(input opcode_e op, input aluFn_e fn,
			input logic setFlags, input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rn,
			input logic [IMM_W-1:0] low);
		instr_u word;
		word.immForm.op       = op;
		word.immForm.fn       = fn;
		word.immForm.setFlags = setFlags;
		word.immForm.rd       = rd;
		word.immForm.rn       = rn;
		word.immForm.imm      = low; // Register form keeps rm in the top 4 bits
		return word;
	endfunction

	task automatic aluModel(input aluFn_e fn, input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b, output logic [DATA_W-1:0] r, output flags_t f);
		logic [DATA_W:0] wide;
		f = '0;
		case (fn)
			ALU_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				r    = wide[DATA_W-1:0];
				f.c  = wide[DATA_W];
				f.v  = (a[DATA_W-1] == b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_SUB: begin
				r   = a - b;
				f.c = (a >= b); // No borrow
				f.v = (a[DATA_W-1] != b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SHL: r = a << b[4:0];
			ALU_SHR: r = a >> b[4:0];
			default: r = b; // MOVB
		endcase
		f.n = r[DATA_W-1];
		f.z = (r == '0);
	endtask

	function automatic logic condHolds(input cond_e cond, input flags_t f);
		case (cond)
			COND_AL: return 1'b1;
			COND_EQ: return f.z;
			COND_NE: return !f.z;
			COND_LT: return f.n != f.v;
			COND_GE: return f.n == f.v;
			default: return 1'b0;
		endcase
	endfunction

	task automatic prepareRows();
		logic [31:0]       rnd;
		logic [DATA_W-1:0] result;
		flags_t            flags;
		flags_t            newFlags;
		flags = '0; // Clear after reset, then carried from row to row
		for (int i = 0; i < ROWS; i++) begin
			rnd       = $random(seed);
			rows[i].a = rnd[DATA_W-1:0];
			rnd       = $random(seed);
			rows[i].b = rows[i].sameOps ? rows[i].a : rnd[DATA_W-1:0];
			aluModel(rows[i].fn, rows[i].a, rows[i].b, result, newFlags);
			rows[i].expResult = result;
			if (rows[i].setFlags)
				flags = newFlags;
			rows[i].expTaken = condHolds(rows[i].cond, flags);
		end
	endtask

	task automatic checkValue(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] want);
		checks++;
		assert (got === want) else begin
			$display("** Error %s: got 0x%06h, expected 0x%06h", name, got, want);
			errors++;
		end
	endtask

	task automatic checkTrue(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			$display("Error: %s", what);
			errors++;
		end
	endtask

	// Starts 1 ns after a rising edge and ends the same way
	task automatic apbTransfer(input logic write, input logic [APB_AW-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic err);
		apbIn.psel    = 1'b1; // Setup cycle
		apbIn.penable = 1'b0;
		apbIn.pwrite  = write;
		apbIn.paddr   = addr;
		apbIn.pwdata  = wdata;
		@(posedge clk);
		#1;
		apbIn.penable = 1'b1;
		#1;
		while (!apbOut.pready) begin // Dmem reads wait here
			@(posedge clk);
			#2;
		end
		rdata = apbOut.prdata;
		err   = apbOut.pslverr;
		@(posedge clk);
		#1;
		apbIn = '0;
	endtask

	task automatic apbWrite(input logic [APB_AW-1:0] addr, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] ignored;
		logic              err;
		apbTransfer(1'b1, addr, data, ignored, err);
		checkTrue(!err, $sformatf("APB write to 0x%03h was rejected", addr));
	endtask

	task automatic apbRead(input logic [APB_AW-1:0] addr, output logic [DATA_W-1:0] data);
		logic err;
		apbTransfer(1'b0, addr, '0, data, err);
		checkTrue(!err, $sformatf("APB read from 0x%03h was rejected", addr));
	endtask

	task automatic runRow(input int i);
		testRow_t          row;
		logic [DATA_W-1:0] prog [7];
		logic [DATA_W-1:0] marker;
		logic [DATA_W-1:0] data;
		logic              err;
		logic              swapLoads;
		row       = rows[i];
		marker    = 24'h5A5A00 ^ DATA_W'(i);
		swapLoads = i[0]; // Odd rows forward r1, even rows r2
		if (swapLoads) begin
			prog[0] = encodeInstr(OP_LOAD, ALU_ADD, 1'b0, 4'd2, 4'd0, 9'd1);
			prog[1] = encodeInstr(OP_LOAD, ALU_ADD, 1'b0, 4'd1, 4'd0, 9'd0);
		end else begin
			prog[0] = encodeInstr(OP_LOAD, ALU_ADD, 1'b0, 4'd1, 4'd0, 9'd0);
			prog[1] = encodeInstr(OP_LOAD, ALU_ADD, 1'b0, 4'd2, 4'd0, 9'd1);
		end
		prog[2] = encodeInstr(OP_ALU, row.fn, row.setFlags, 4'd3, 4'd1, {4'd2, 5'd0});
		prog[3] = encodeInstr(OP_STORE, ALU_ADD, 1'b0, 4'd3, 4'd0, 9'd2);
		prog[4] = encodeInstr(OP_BRANCH, ALU_ADD, 1'b0, row.cond, 4'd0, 9'd1); // Over word 5
		prog[5] = encodeInstr(OP_STORE, ALU_ADD, 1'b0, 4'd1, 4'd0, 9'd3);
		prog[6] = encodeInstr(OP_HALT, ALU_ADD, 1'b0, 4'd0, 4'd0, 9'd0);

		apbWrite(dmemAddr(0), row.a);
		apbWrite(dmemAddr(1), row.b);
		apbWrite(dmemAddr(3), marker);
		for (int k = 0; k < 7; k++)
			apbWrite(imemAddr(k), prog[k]);
		apbWrite(CTRL_ADDR, 24'h1);

		// Core owns dmem while running
		apbTransfer(1'b1, dmemAddr(0), ~row.a, data, err);
		checkTrue(err, $sformatf("row %0d dmem write while running got no pslverr", i));

		data = '0;
		while (!data[1])
			apbRead(CTRL_ADDR, data);
		checkValue($sformatf("row %0d status", i), data, 24'h2);
		apbRead(dmemAddr(2), data);
		checkValue($sformatf("row %0d dmem[2]", i), data, row.expResult);
		apbRead(dmemAddr(3), data);
		checkValue($sformatf("row %0d dmem[3]", i), data, row.expTaken ? marker : row.a);
		apbRead(dmemAddr(0), data);
		checkValue($sformatf("row %0d dmem[0]", i), data, row.a);
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : mainFlow
		logic [DATA_W-1:0] data;
		seed   = 32'hade0_113b;
		errors = 0;
		checks = 0;
		reset  = 1'b1;
		apbIn  = '0;
		prepareRows();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		apbRead(CTRL_ADDR, data);
		checkValue("status after reset", data, '0);
		apbRead(dmemAddr(DMEM_WORDS - 1), data);
		checkValue("dmem[63] after reset", data, '0);

		for (int i = 0; i < ROWS; i++)
			runRow(i);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sim/cpuTb_assert.sv */
// **********************************************************
// Concurrent checks on the APB port and the run state,
// bound into apbControl. Dmem reads may wait one cycle
// **********************************************************
`timescale 1ns/1ps

module apbRunChecks (
	input logic              clk,
	input logic              reset,
	input pipePkg::apbReq_t  apbIn,
	input pipePkg::apbResp_t apbOut,
	input logic              run,
	input logic              halted
);
	logic       access;
	logic [1:0] waitCount;

	assign access = apbIn.psel && apbIn.penable;

	always_ff @(posedge clk) begin
		if (reset || !access || apbOut.pready)
			waitCount <= '0;
		else if (waitCount != 2'd3)
			waitCount <= waitCount + 2'd1; // Access cycles without pready
	end

	readyInTime: assert property (@(posedge clk) disable iff (reset)
		!access || apbOut.pready || waitCount < 2'd2)
		else $error("pready did not rise within 2 cycles of penable");

	errorWithReady: assert property (@(posedge clk) disable iff (reset)
		apbOut.pslverr |-> apbOut.pready)
		else $error("pslverr was high while pready was low");

	runOrHalted: assert property (@(posedge clk) disable iff (reset)
		!(run && halted))
		else $error("run and halted were set together");

endmodule

bind apbControl apbRunChecks i_apbRunChecks (
	.clk    (clk),
	.reset  (reset),
	.apbIn  (apbIn),
	.apbOut (apbOut),
	.run    (run),
	.halted (halted)
);

/* src/apbControl.sv */
// **********************************************************
// APB slave for the core. Control at 0x000, imem at 0x1xx,
// dmem at 0x2xx. Memory access while running and unmapped
// addresses complete with pslverr. Imem is write only.
// Dmem reads take one wait state, all else none
// **********************************************************
`timescale 1ns/1ps

module apbControl (
	input  logic                      clk,
	input  logic                      reset,
	input  pipePkg::apbReq_t          apbIn,
	output pipePkg::apbResp_t         apbOut,
	input  logic                      haltE,
	input  logic [isaPkg::DATA_W-1:0] dmemRdata,
	output logic                      run,
	output pipePkg::memWr_t           memWr
);
	import isaPkg::*;

	logic access;
	logic ctrlHit;
	logic imemHit;
	logic dmemHit;
	logic badAccess;
	logic dmemRead;
	logic ctrlWrite;
	logic ready;
	logic waitDone;
	logic halted;

	assign access    = apbIn.psel && apbIn.penable;
	assign ctrlHit   = (apbIn.paddr == '0);
	assign imemHit   = (apbIn.paddr[11:8] == 4'h1);
	assign dmemHit   = (apbIn.paddr[11:8] == 4'h2);
	// Unmapped, memory busy with the core, or an imem read
	assign badAccess = !(ctrlHit || imemHit || dmemHit) ||
		((imemHit || dmemHit) && run) || (imemHit && !apbIn.pwrite);
	assign dmemRead  = dmemHit && !apbIn.pwrite && !badAccess;
	assign ctrlWrite = access && apbIn.pwrite && ctrlHit;
	assign ready     = access && (!dmemRead || waitDone);

	always_comb begin
		apbOut.pready  = ready;
		apbOut.pslverr = ready && badAccess;
		apbOut.prdata  = '0;
		if (ctrlHit)
			apbOut.prdata = DATA_W'({halted, run}); // Bit 1 halted, bit 0 run
		else if (dmemRead)
			apbOut.prdata = dmemRdata;
	end

	always_comb begin
		memWr.imemWe = access && apbIn.pwrite && imemHit && !badAccess;
		memWr.dmemWe = access && apbIn.pwrite && dmemHit && !badAccess;
		memWr.dmemRe = access && dmemRead && !waitDone; // First access cycle only
		memWr.addr   = apbIn.paddr[MEM_AW+1:2];
		memWr.wdata  = apbIn.pwdata;
	end

	always_ff @(posedge clk) begin
		if (reset)
			waitDone <= 1'b0;
		else
			waitDone <= access && dmemRead && !waitDone;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			run    <= 1'b0;
			halted <= 1'b0;
		end else if (haltE) begin // Halt wins over a same-cycle write
			run    <= 1'b0;
			halted <= 1'b1;
		end else if (ctrlWrite) begin
			run <= apbIn.pwdata[0];
			if (apbIn.pwdata[0])
				halted <= 1'b0;
		end
	end

endmodule

/* src/cpuTop.sv */
// **********************************************************
// Top of the four-stage core behind an APB slave port
// Load memories while stopped, then set run
// **********************************************************
`timescale 1ns/1ps

module cpuTop (
	input  logic                clk,
	input  logic                reset,
	input  pipePkg::apbReq_t    apbIn,
	output pipePkg::apbResp_t   apbOut
);
	import isaPkg::*;
	import pipePkg::*;

	logic              run;
	logic              haltE;
	logic              fwdA;
	logic              fwdB;
	logic [DATA_W-1:0] dmemRdata;
	memWr_t            memWr;
	redirect_t         redirect;
	fdBundle_t         fd;
	wbPort_t           wb;
	deCtrl_t           ctrlD;
	deCtrl_t           ctrlE;
	deData_t           dataD;
	deData_t           dataE;

	apbControl i_apbControl (
		.clk       (clk),
		.reset     (reset),
		.apbIn     (apbIn),
		.apbOut    (apbOut),
		.haltE     (haltE),
		.dmemRdata (dmemRdata),
		.run       (run),
		.memWr     (memWr)
	);

	fetchStage i_fetchStage (
		.clk      (clk),
		.reset    (reset),
		.run      (run),
		.redirect (redirect),
		.memWr    (memWr),
		.fd       (fd)
	);

	decodeStage i_decodeStage (
		.clk   (clk),
		.reset (reset),
		.fd    (fd),
		.wb    (wb),
		.ctrlD (ctrlD),
		.dataD (dataD)
	);

	registerDE i_registerDE (
		.clk   (clk),
		.reset (reset),
		.clr   (redirect.taken), // Flush behind a branch or halt
		.ctrlD (ctrlD),
		.dataD (dataD),
		.ctrlE (ctrlE),
		.dataE (dataE),
		.fwdA  (fwdA),
		.fwdB  (fwdB)
	);

	executeStage i_executeStage (
		.clk       (clk),
		.reset     (reset),
		.ctrlE     (ctrlE),
		.dataE     (dataE),
		.fwdA      (fwdA),
		.fwdB      (fwdB),
		.memWr     (memWr),
		.wb        (wb),
		.redirect  (redirect),
		.haltE     (haltE),
		.dmemRdata (dmemRdata)
	);

endmodule

/* src/decodeStage.sv */
// **********************************************************
// Decode stage. Control decode, 16 x 24 register file and
// immediate sign extension. Register file writes through
// to the read ports so a distance of two needs no forward
// **********************************************************
`timescale 1ns/1ps

module decodeStage (
	input  logic                 clk,
	input  logic                 reset,
	input  pipePkg::fdBundle_t   fd,
	input  pipePkg::wbPort_t     wb,
	output pipePkg::deCtrl_t     ctrlD,
	output pipePkg::deData_t     dataD
);
	import isaPkg::*;

	logic [DATA_W-1:0] regs [REG_COUNT];
	logic [REG_AW-1:0] ra1;
	logic [REG_AW-1:0] ra2;
	logic [REG_AW-1:0] a3;
	logic [DATA_W-1:0] extImm;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb.we) begin
			regs[wb.a3] <= wb.value;
		end
	end

	assign extImm = {{(DATA_W-IMM_W){fd.instr.immForm.imm[IMM_W-1]}}, fd.instr.immForm.imm};

	always_comb begin
		ctrlD       = '0;
		ctrlD.valid = fd.valid;
		ctrlD.aluFn = ALU_ADD; // Address add for load and store
		ctrlD.cond  = COND_AL;
		ra1         = fd.instr.regForm.rn;
		ra2         = fd.instr.regForm.rm;
		a3          = fd.instr.regForm.rd;
		if (fd.valid) begin
			case (fd.instr.regForm.op)
				OP_ALU: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.aluFn    = fd.instr.regForm.fn;
					ctrlD.setFlags = fd.instr.regForm.setFlags;
				end
				OP_ALUI: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.useImm   = 1'b1;
					ctrlD.aluFn    = fd.instr.immForm.fn;
					ctrlD.setFlags = fd.instr.immForm.setFlags;
					ra1            = fd.instr.immForm.rn;
					a3             = fd.instr.immForm.rd;
				end
				OP_LOAD: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.memToReg = 1'b1;
					ctrlD.useImm   = 1'b1;
					ra1            = fd.instr.immForm.rn;
					a3             = fd.instr.immForm.rd;
				end
				OP_STORE: begin
					ctrlD.memWrite = 1'b1;
					ctrlD.useImm   = 1'b1;
					ra1            = fd.instr.immForm.rn;
					ra2            = fd.instr.immForm.rd; // Store data
				end
				OP_BRANCH: begin
					ctrlD.branch = 1'b1;
					ctrlD.cond   = cond_e'(fd.instr.immForm.rd);
				end
				OP_HALT: ctrlD.halt = 1'b1;
				default: ;
			endcase
		end
	end

	always_comb begin
		dataD.pc     = fd.pc;
		dataD.rd1    = (wb.we && wb.a3 == ra1) ? wb.value : regs[ra1];
		dataD.rd2    = (wb.we && wb.a3 == ra2) ? wb.value : regs[ra2];
		dataD.extImm = extImm;
		dataD.a3     = a3;
		dataD.ra1    = ra1;
		dataD.ra2    = ra2;
	end

endmodule

/* src/executeStage.sv */
// **********************************************************
// Execute stage with ALU, NZCV flags, branch and halt, data
// memory and the execute/writeback register. Branches test
// the flags from before this instruction. Dmem goes to the
// APB side whenever APB drives an enable
// **********************************************************
`timescale 1ns/1ps

module executeStage (
	input  logic                      clk,
	input  logic                      reset,
	input  pipePkg::deCtrl_t          ctrlE,
	input  pipePkg::deData_t          dataE,
	input  logic                      fwdA,
	input  logic                      fwdB,
	input  pipePkg::memWr_t           memWr,
	output pipePkg::wbPort_t          wb,
	output pipePkg::redirect_t        redirect,
	output logic                      haltE,
	output logic [isaPkg::DATA_W-1:0] dmemRdata
);
	import isaPkg::*;
	import pipePkg::*;

	logic [DATA_W-1:0] srcA;
	logic [DATA_W-1:0] srcB;
	logic [DATA_W-1:0] storeData;
	logic [DATA_W-1:0] bAdj;
	logic [DATA_W:0]   sum;
	logic              subOp;
	logic              arith;
	logic [DATA_W-1:0] aluResult;
	flags_t            flags;
	flags_t            aluFlags;
	logic              condMet;
	logic [DATA_W-1:0] dmem [DMEM_WORDS];
	logic [DATA_W-1:0] dmemQ;
	logic [MEM_AW-1:0] dmemAddr;
	logic [DATA_W-1:0] dmemWdata;
	logic              dmemWe;
	logic              apbSide;
	ewBundle_t         ew;

	assign srcA      = fwdA ? wb.value : dataE.rd1; // From writeback
	assign storeData = fwdB ? wb.value : dataE.rd2;
	assign srcB      = ctrlE.useImm ? dataE.extImm : storeData;

	assign subOp = (ctrlE.aluFn == ALU_SUB);
	assign arith = (ctrlE.aluFn == ALU_ADD) || subOp;
	assign bAdj  = subOp ? ~srcB : srcB;
	assign sum   = {1'b0, srcA} + {1'b0, bAdj} + (DATA_W+1)'(subOp);

	always_comb begin
		case (ctrlE.aluFn)
			ALU_AND: aluResult = srcA & srcB;
			ALU_OR:  aluResult = srcA | srcB;
			ALU_XOR: aluResult = srcA ^ srcB;
			ALU_SHL: aluResult = srcA << srcB[4:0];
			ALU_SHR: aluResult = srcA >> srcB[4:0];
			ALU_MOVB: aluResult = srcB;
			default: aluResult = sum[DATA_W-1:0]; // ADD and SUB
		endcase
		aluFlags.n = aluResult[DATA_W-1];
		aluFlags.z = (aluResult == '0);
		aluFlags.c = arith && sum[DATA_W];
		aluFlags.v = arith && (srcA[DATA_W-1] == bAdj[DATA_W-1]) &&
			(sum[DATA_W-1] != srcA[DATA_W-1]);
	end

	always_ff @(posedge clk) begin
		if (reset)
			flags <= '0;
		else if (ctrlE.valid && ctrlE.setFlags)
			flags <= aluFlags;
	end

	always_comb begin
		case (ctrlE.cond)
			COND_AL: condMet = 1'b1;
			COND_EQ: condMet = flags.z;
			COND_NE: condMet = !flags.z;
			COND_LT: condMet = (flags.n != flags.v);
			COND_GE: condMet = (flags.n == flags.v);
			default: condMet = 1'b0;
		endcase
	end

	assign redirect.taken  = (ctrlE.branch && condMet) || ctrlE.halt;
	assign redirect.target = dataE.pc + PC_W'(1) + dataE.extImm[PC_W-1:0];
	assign haltE           = ctrlE.halt;

	assign apbSide   = memWr.dmemRe || memWr.dmemWe;
	assign dmemAddr  = apbSide ? memWr.addr : aluResult[MEM_AW-1:0];
	assign dmemWe    = apbSide ? memWr.dmemWe : ctrlE.memWrite;
	assign dmemWdata = apbSide ? memWr.wdata : storeData;
	assign dmemRdata = dmemQ;

	always_ff @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr] <= dmemWdata;
		dmemQ <= dmem[dmemAddr]; // Old data on a same-cycle write
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ew.regWrite <= 1'b0;
			ew.memToReg <= 1'b0;
		end else begin
			ew.regWrite <= ctrlE.regWrite;
			ew.memToReg <= ctrlE.memToReg;
		end
	end

	always_ff @(posedge clk) begin
		ew.a3        <= dataE.a3;
		ew.aluResult <= aluResult;
	end

	assign wb.we    = ew.regWrite;
	assign wb.a3    = ew.a3;
	assign wb.value = ew.memToReg ? dmemQ : ew.aluResult;

endmodule

/* src/fetchStage.sv */
// **********************************************************
// Fetch stage with PC, instruction memory and the
// fetch/decode register. PC sits at 0 while run is low,
// so every start begins at word 0. Imem is loaded over APB
// **********************************************************
`timescale 1ns/1ps

module fetchStage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 run,
	input  pipePkg::redirect_t   redirect,
	input  pipePkg::memWr_t      memWr,
	output pipePkg::fdBundle_t   fd
);
	import isaPkg::*;

	logic [DATA_W-1:0] imem [IMEM_WORDS];
	logic [PC_W-1:0]   pc;

	always_ff @(posedge clk) begin
		if (memWr.imemWe)
			imem[memWr.addr] <= memWr.wdata;
	end

	always_ff @(posedge clk) begin
		if (reset || !run)
			pc <= '0;
		else if (redirect.taken)
			pc <= redirect.target;
		else
			pc <= pc + 1'b1;
	end

	// Flushed on a taken branch or halt
	always_ff @(posedge clk) begin
		if (reset || redirect.taken) begin
			fd <= '0;
		end else begin
			fd.valid <= run; // Bubbles while stopped
			fd.pc    <= pc;
			fd.instr <= imem[pc];
		end
	end

endmodule

/* src/isaPkg.sv */
// **********************************************************
// ISA definitions for the 24-bit four-stage core
// Instruction and data words share one width
// Memories are word addressed, 64 words each
// Register 0 is an ordinary register
// **********************************************************
package isaPkg;

	localparam int DATA_W     = 24;
	localparam int REG_COUNT  = 16;
	localparam int REG_AW     = $clog2(REG_COUNT);
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int PC_W       = $clog2(IMEM_WORDS);
	localparam int MEM_AW     = $clog2(DMEM_WORDS);
	localparam int IMM_W      = 9;

	typedef enum logic [2:0] {
		OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH, OP_HALT
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_MOVB
	} aluFn_e;

	// Held in the rd field of a branch
	typedef enum logic [3:0] {
		COND_AL, COND_EQ, COND_NE, COND_LT, COND_GE
	} cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c; // Carry out, or no borrow on SUB
		logic v;
	} flags_t;

	// Both views start with op, fn and setFlags
	typedef union packed {
		struct packed {
			opcode_e           op;
			aluFn_e            fn;
			logic              setFlags;
			logic [REG_AW-1:0] rd;
			logic [REG_AW-1:0] rn;
			logic [REG_AW-1:0] rm;
			logic [4:0]        spare;
		} regForm;
		struct packed {
			opcode_e           op;
			aluFn_e            fn;
			logic              setFlags;
			logic [REG_AW-1:0] rd; // Condition for a branch
			logic [REG_AW-1:0] rn;
			logic [IMM_W-1:0]  imm; // Signed
		} immForm;
	} instr_u;

endpackage

/* src/pipePkg.sv */
// **********************************************************
// Pipeline register bundles and APB port structs
// APB data is one machine word wide
// paddr carries a byte address, words at bits 7 to 2
// **********************************************************
package pipePkg;

	import isaPkg::*;

	localparam int APB_AW = 12;

	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		instr_u          instr;
	} fdBundle_t;

	typedef struct packed {
		logic   valid;
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		logic   useImm;
		logic   branch;
		logic   halt;
		logic   setFlags;
		aluFn_e aluFn;
		cond_e  cond;
	} deCtrl_t;

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [DATA_W-1:0] rd1;
		logic [DATA_W-1:0] rd2;
		logic [DATA_W-1:0] extImm;
		logic [REG_AW-1:0] a3;
		logic [REG_AW-1:0] ra1;
		logic [REG_AW-1:0] ra2;
	} deData_t;

	typedef struct packed {
		logic              regWrite;
		logic              memToReg;
		logic [REG_AW-1:0] a3;
		logic [DATA_W-1:0] aluResult;
	} ewBundle_t;

	typedef struct packed {
		logic              we;
		logic [REG_AW-1:0] a3;
		logic [DATA_W-1:0] value;
	} wbPort_t;

	typedef struct packed {
		logic            taken;
		logic [PC_W-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apbResp_t;

	typedef struct packed {
		logic              imemWe;
		logic              dmemWe;
		logic              dmemRe;
		logic [MEM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} memWr_t;

endpackage

/* src/registerDE.sv */
// **********************************************************
// Decode/execute register. clr turns the entry into a bubble
// Forward selects are worked out one cycle early here
// **********************************************************
`timescale 1ns/1ps

module registerDE (
	input  logic               clk,
	input  logic               reset,
	input  logic               clr,
	input  pipePkg::deCtrl_t   ctrlD,
	input  pipePkg::deData_t   dataD,
	output pipePkg::deCtrl_t   ctrlE,
	output pipePkg::deData_t   dataE,
	output logic               fwdA,
	output logic               fwdB
);
	logic olderWrites;

	// Instruction now in execute moves to writeback next
	assign olderWrites = ctrlE.valid && ctrlE.regWrite;

	always_ff @(posedge clk) begin
		if (reset || clr) begin
			ctrlE <= '0;
			dataE <= '0;
			fwdA  <= 1'b0;
			fwdB  <= 1'b0;
		end else begin
			ctrlE <= ctrlD;
			dataE <= dataD;
			fwdA  <= olderWrites && (dataD.ra1 == dataE.a3);
			fwdB  <= olderWrites && (dataD.ra2 == dataE.a3);
		end
	end

endmodule
